/* Makefile */
TOP = tb_eeprom_i2c

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

obj_dir/V$(TOP): src.f $(wildcard hdl/*.sv verif/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

/* hdl/eeprom_axil_regs.sv */
`timescale 1ns/1ps

module eeprom_axil_regs
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic        busy,
    input  logic        done_pulse,
    input  logic        nack_flag,
    input  logic [7:0]  rd_byte,
    output logic        cmd_start,
    output cmd_word_u   cmd_word
);

    logic wr_accept;
    logic rd_accept;
    logic cmd_wr;
    logic busy_any;
    logic done_q;   // sticky

    // address and data taken together, one outstanding response
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;
    assign awready = wr_accept;
    assign wready = wr_accept;
    assign arready = rd_accept;
    assign rresp = 2'b00;

    assign cmd_wr = wr_accept && (awaddr == REG_CMD);
    assign busy_any = busy || cmd_start;  // busy shows a cycle late

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            cmd_start <= 1'b0;
            cmd_word <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            cmd_start <= 1'b0;
            if (wr_accept)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rd_accept)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            if (cmd_wr && !busy_any)
            begin
                cmd_word.raw <= wdata;
                cmd_start <= 1'b1;
            end

            if (done_pulse)
                done_q <= 1'b1;
            else if (rd_accept && (araddr == REG_STATUS))
                done_q <= 1'b0;   // cleared by the status read
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_accept)
            bresp <= (cmd_wr && busy_any) ? 2'b10 : 2'b00;  // slverr when busy
        if (rd_accept)
        begin
            case (araddr)
                REG_CMD:    rdata <= cmd_word.raw;
                REG_STATUS: rdata <= {16'h0, rd_byte, 5'b0, nack_flag, done_q, busy};
                default:    rdata <= 32'h0;
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (RESET) bvalid && !bready |=> bvalid);

endmodule

/* hdl/eeprom_ctrl.sv */
`timescale 1ns/1ps

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_start,
    input  cmd_word_u  cmd_word,
    input  logic       cond_done,
    input  logic       byte_done,
    input  logic       ack_bit,
    input  logic [7:0] rx_byte,
    output logic       busy,
    output logic       done_pulse,
    output logic       nack_flag,
    output logic [7:0] rd_byte,
    output logic       cond_req,
    output cond_kind_e cond_kind,
    output logic       byte_req,
    output logic       byte_dir,
    output logic [7:0] tx_byte,
    output logic       master_nack
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic [2:0] page;       // addr bits 10:8, sent in the control byte
    logic       slave_nack;

    assign page = cmd_word.f.addr[ADDR_BITS-1:8];
    assign slave_nack = byte_done && ack_bit && !byte_dir;

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE, DONE:
                if (cmd_start)
                    state_nxt = START;
                else
                    state_nxt = IDLE;
            START:
                if (cond_done)
                    state_nxt = CTRL_W;
            CTRL_W:
                if (slave_nack)
                    state_nxt = STOP;
                else if (byte_done)
                    state_nxt = ADDR;
            ADDR:
                if (slave_nack)
                    state_nxt = STOP;
                else if (byte_done)
                    state_nxt = cmd_word.f.op ? RESTART : WDATA;
            WDATA:
                if (byte_done)
                    state_nxt = STOP;
            RESTART:
                if (cond_done)
                    state_nxt = CTRL_R;
            CTRL_R:
                if (slave_nack)
                    state_nxt = STOP;
                else if (byte_done)
                    state_nxt = RDATA;
            RDATA:
                if (byte_done)
                    state_nxt = STOP;
            STOP:
                if (cond_done)
                    state_nxt = DONE;
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            nack_flag <= 1'b0;
            rd_byte <= 8'h00;
        end
        else
        begin
            state <= state_nxt;
            if (cmd_start)
                nack_flag <= 1'b0;
            else if (slave_nack)
                nack_flag <= 1'b1;
            if (byte_done && (state == RDATA))
                rd_byte <= rx_byte;
        end
    end

    assign busy = !((state == IDLE) || (state == DONE));
    assign done_pulse = (state == DONE);

    assign cond_req = (state == START) || (state == RESTART) || (state == STOP);
    assign cond_kind = (state == STOP) ? COND_STOP : COND_START;
    assign byte_req = state inside {CTRL_W, ADDR, WDATA, CTRL_R, RDATA};
    assign byte_dir = (state == RDATA);
    assign master_nack = 1'b1;  // single byte read ends with nack

    always_comb
    begin
        case (state)
            CTRL_W:  tx_byte = {CTRL_CODE, page, 1'b0};
            ADDR:    tx_byte = cmd_word.f.addr[7:0];
            WDATA:   tx_byte = cmd_word.f.data;
            CTRL_R:  tx_byte = {CTRL_CODE, page, 1'b1};
            default: tx_byte = 8'h00;
        endcase
    end

    assert property (@(posedge CLK) disable iff (RESET) $onehot(state));
    assert property (@(posedge CLK) disable iff (RESET) !(cond_req && byte_req));

endmodule

/* hdl/eeprom_i2c_top.sv */
`timescale 1ns/1ps

module eeprom_i2c_top
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        scl,
    output logic        sda_oe,   // pull SDA low
    input  logic        sda_in
);

    logic       cmd_start;
    cmd_word_u  cmd_word;
    logic       busy;
    logic       done_pulse;
    logic       nack_flag;
    logic [7:0] rd_byte;
    logic       cond_req;
    cond_kind_e cond_kind;
    logic       cond_done;
    logic       byte_req;
    logic       byte_dir;
    logic [7:0] tx_byte;
    logic       master_nack;
    logic       byte_done;
    logic       ack_bit;
    logic [7:0] rx_byte;
    logic       q_tick;
    logic [1:0] phase;
    logic       byte_active;
    logic       cg_scl_low;
    logic       cg_sda_low;
    logic       bs_scl_low;
    logic       bs_sda_low;

    eeprom_axil_regs i_regs (.*);

    eeprom_ctrl i_ctrl (.*);

    i2c_cond_gen i_cond (
        .CLK         (CLK),
        .RESET       (RESET),
        .cond_req    (cond_req),
        .cond_kind   (cond_kind),
        .byte_active (byte_active),
        .cond_done   (cond_done),
        .q_tick      (q_tick),
        .phase       (phase),
        .scl_low     (cg_scl_low),
        .sda_low     (cg_sda_low)
    );

    i2c_byte_shifter i_shift (
        .CLK         (CLK),
        .RESET       (RESET),
        .byte_req    (byte_req),
        .byte_dir    (byte_dir),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .q_tick      (q_tick),
        .phase       (phase),
        .sda_in      (sda_in),
        .byte_done   (byte_done),
        .ack_bit     (ack_bit),
        .rx_byte     (rx_byte),
        .active      (byte_active),
        .scl_low     (bs_scl_low),
        .sda_low     (bs_sda_low)
    );

    // open drain, either engine may pull low
    assign scl = !(cg_scl_low || bs_scl_low);
    assign sda_oe = cg_sda_low || bs_sda_low;

endmodule

/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int QUARTER_CYCLES = 4;          // CLK cycles per quarter of an SCL bit
    localparam logic [3:0] CTRL_CODE = 4'b1010; // 24Cxx device type
    localparam int ADDR_BITS = 11;

    localparam logic [3:0] REG_CMD    = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;

    // host command word, raw as written over AXI
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic                 op;   // 1 = random read
            logic [11:0]          rsvd;
            logic [ADDR_BITS-1:0] addr;
            logic [7:0]           data;
        } f;
    } cmd_word_u;

    typedef enum logic [9:0] {
        IDLE    = 10'b00_0000_0001,
        START   = 10'b00_0000_0010,
        CTRL_W  = 10'b00_0000_0100,
        ADDR    = 10'b00_0000_1000,
        WDATA   = 10'b00_0001_0000,
        RESTART = 10'b00_0010_0000,
        CTRL_R  = 10'b00_0100_0000,
        RDATA   = 10'b00_1000_0000,
        STOP    = 10'b01_0000_0000,
        DONE    = 10'b10_0000_0000
    } ctrl_state_e;

    typedef enum logic [1:0] {
        COND_START = 2'd0,  // also the repeated start
        COND_STOP  = 2'd1
    } cond_kind_e;

endpackage

/* hdl/i2c_byte_shifter.sv */
`timescale 1ns/1ps

module i2c_byte_shifter
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       byte_req,
    input  logic       byte_dir,
    input  logic [7:0] tx_byte,
    input  logic       master_nack,
    input  logic       q_tick,
    input  logic [1:0] phase,
    input  logic       sda_in,
    output logic       byte_done,
    output logic       ack_bit,
    output logic [7:0] rx_byte,
    output logic       active,
    output logic       scl_low,
    output logic       sda_low
);

    logic       dir_q;      // 1 = receive
    logic [7:0] shreg;
    logic [3:0] bit_cnt;
    logic       ack_slot;

    assign ack_slot = (bit_cnt == 4'd8);
    assign byte_done = active && q_tick && (phase == 2'd3) && ack_slot;
    assign rx_byte = shreg;

    // SCL high in the middle two quarters of every bit
    assign scl_low = active && ((phase == 2'd0) || (phase == 2'd3));

    always_comb
    begin
        if (!active)
            sda_low = 1'b0;
        else if (ack_slot)
            sda_low = dir_q && !master_nack;  // released for slave ack
        else
            sda_low = !dir_q && !shreg[7];
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            dir_q <= 1'b0;
            bit_cnt <= 4'd0;
        end
        else if (!active)
        begin
            if (byte_req)
            begin
                active <= 1'b1;
                dir_q <= byte_dir;
                bit_cnt <= 4'd0;
            end
        end
        else if (q_tick && (phase == 2'd3))
        begin
            bit_cnt <= bit_cnt + 4'd1;
            if (ack_slot)
                active <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && byte_req)
            shreg <= byte_dir ? 8'h00 : tx_byte;
        else if (active && q_tick)
        begin
            if (ack_slot)
            begin
                if (phase == 2'd2)
                    ack_bit <= sda_in;
            end
            else if (dir_q && (phase == 2'd2))
                shreg <= {shreg[6:0], sda_in};  // sample at end of SCL high
            else if (!dir_q && (phase == 2'd3))
                shreg <= {shreg[6:0], 1'b0};    // next bit, msb first
        end
    end

endmodule

/* hdl/i2c_cond_gen.sv */
`timescale 1ns/1ps

module i2c_cond_gen
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cond_req,
    input  cond_kind_e cond_kind,
    input  logic       byte_active,
    output logic       cond_done,
    output logic       q_tick,
    output logic [1:0] phase,
    output logic       scl_low,
    output logic       sda_low
);

    logic [$clog2(QUARTER_CYCLES)-1:0] div_cnt;
    logic cond_busy;
    logic scl_hold;     // bus owned, park SCL low between bytes
    logic run;

    assign run = cond_busy || byte_active;
    assign q_tick = run && (div_cnt == QUARTER_CYCLES - 1);
    assign cond_done = cond_busy && q_tick && (phase == 2'd3);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            div_cnt <= '0;
            phase <= 2'd0;
            cond_busy <= 1'b0;
            scl_hold <= 1'b0;
        end
        else
        begin
            if (!run || q_tick)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
            if (q_tick)
                phase <= phase + 2'd1;  // wraps to 0 at every operation end

            if (cond_done)
            begin
                cond_busy <= 1'b0;
                scl_hold <= (cond_kind == COND_START);
            end
            else if (cond_req && !cond_busy)
                cond_busy <= 1'b1;
        end
    end

    always_comb
    begin
        scl_low = scl_hold && !byte_active;
        sda_low = 1'b0;
        if (cond_busy)
        begin
            if (cond_kind == COND_START)
            begin
                scl_low = (phase == 2'd0) || (phase == 2'd3);
                sda_low = phase[1];   // falls with SCL high
            end
            else
            begin
                scl_low = (phase == 2'd0);
                sda_low = !phase[1];  // rises with SCL high
            end
        end
    end

    assert property (@(posedge CLK) disable iff (RESET) !q_tick |=> $stable(phase));

endmodule

/* src.f */
hdl/eeprom_pkg.sv
hdl/eeprom_axil_regs.sv
hdl/eeprom_ctrl.sv
hdl/i2c_cond_gen.sv
hdl/i2c_byte_shifter.sv
hdl/eeprom_i2c_top.sv
verif/eeprom_model.sv
verif/tb_eeprom_i2c.sv

/* verif/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model
(
    input  logic CLK,
    input  logic en,       // 0 = never acknowledge
    input  logic scl,
    input  logic sda,
    output logic pull      // pull SDA low
);

    typedef enum logic [2:0] {S_IDLE, S_CTRL, S_ADDR, S_WDATA, S_READ} slave_state_e;

    logic [7:0]   mem [0:2047];
    slave_state_e st;
    logic         prev_scl;
    logic         prev_sda;
    logic [3:0]   bit_cnt;
    logic [7:0]   shreg;
    logic [10:0]  ptr;
    logic         ack_phase;
    logic         rd_go;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ {a[10:8], 5'b10101};
        st = S_IDLE;
        pull = 1'b0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
        ack_phase = 1'b0;
        rd_go = 1'b0;
        bit_cnt = 4'd0;
        ptr = '0;
    end

    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (scl && prev_scl && prev_sda && !sda)
        begin
            st <= S_CTRL;          // start or repeated start
            bit_cnt <= 4'd0;
            ack_phase <= 1'b0;
            pull <= 1'b0;
        end
        else if (scl && prev_scl && !prev_sda && sda)
        begin
            st <= S_IDLE;          // stop
            pull <= 1'b0;
        end
        else if (scl && !prev_scl)
        begin
            if (st == S_READ)
            begin
                if (bit_cnt == 4'd8)
                    st <= S_IDLE;  // master nack ends the read
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else if (st != S_IDLE && bit_cnt < 4'd8)
            begin
                shreg <= {shreg[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
        else if (!scl && prev_scl)
        begin
            if (ack_phase)
            begin
                ack_phase <= 1'b0;
                bit_cnt <= 4'd0;
                if (rd_go)
                begin
                    st <= S_READ;
                    shreg <= mem[ptr];
                    pull <= !mem[ptr][7];
                    rd_go <= 1'b0;
                end
                else
                    pull <= 1'b0;
            end
            else if (st == S_READ)
            begin
                shreg <= {shreg[6:0], 1'b0};
                pull <= (bit_cnt < 4'd8) && !shreg[6];
            end
            else if (st != S_IDLE && bit_cnt == 4'd8)
            begin
                ack_phase <= 1'b1;
                case (st)
                    S_CTRL:
                        if (en && shreg[7:4] == 4'b1010)
                        begin
                            pull <= 1'b1;
                            ptr[10:8] <= shreg[3:1];
                            rd_go <= shreg[0];
                            st <= shreg[0] ? S_CTRL : S_ADDR;
                        end
                        else
                            st <= S_IDLE;
                    S_ADDR:
                    begin
                        pull <= en;
                        ptr[7:0] <= shreg;
                        st <= S_WDATA;
                    end
                    default:
                    begin
                        pull <= en;
                        if (en)
                            mem[ptr] <= shreg;
                        st <= S_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* verif/tb_eeprom_i2c.sv */
`timescale 1ns/1ps

module tb_eeprom_i2c;

    logic        CLK;
    logic        RESET;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        scl;
    logic        sda_oe;
    logic        model_pull;
    logic        model_en;
    wire         sda = !(sda_oe || model_pull);   // wired-AND

    logic [7:0]  ref_mem [0:2047];
    logic [31:0] seed;
    int          errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] exp_mask;
    logic [31:0] exp_val;
    logic        chk_en;
    logic        chk_poll;   // only the read that shows done is checked
    logic [1:0]  exp_bresp;
    logic        idle_chk;
    logic [2:0]  exp_page;
    logic [7:0]  cap_byte;
    logic [3:0]  cap_cnt;
    logic        cap_valid;
    int          n_start;
    logic        prev_scl;
    logic        prev_sda;

    eeprom_i2c_top i_eeprom_i2c_top (.*, .sda_in(sda));

    eeprom_model i_model (.CLK(CLK), .en(model_en), .scl(scl), .sda(sda), .pull(model_pull));

    always #10 CLK = !CLK;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // capture the first byte after every start
    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        cap_valid <= 1'b0;
        if (scl && prev_scl && prev_sda && !sda)
        begin
            n_start <= n_start + 1;
            cap_cnt <= 4'd0;
        end
        else if (scl && prev_scl && !prev_sda && sda)
            n_start <= 0;
        else if (scl && !prev_scl && cap_cnt < 4'd8)
        begin
            cap_byte <= {cap_byte[6:0], sda};
            cap_cnt <= cap_cnt + 4'd1;
            cap_valid <= (cap_cnt == 4'd7);
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        rvalid && rready && chk_en && (!chk_poll || rdata[1]) |-> (rdata & exp_mask) == exp_val)
    else
    begin
        errors++;
        $display("[ERROR] %0t rdata expected %h got %h", $time, exp_val, rdata & exp_mask);
    end

    assert property (@(posedge CLK) disable iff (RESET) rvalid && rready |-> rresp == 2'b00)
    else
    begin
        errors++;
        $display("[ERROR] %0t rresp expected %h got %h", $time, 2'b00, rresp);
    end

    assert property (@(posedge CLK) disable iff (RESET) bvalid && bready |-> bresp == exp_bresp)
    else
    begin
        errors++;
        $display("[ERROR] %0t bresp expected %h got %h", $time, exp_bresp, bresp);
    end

    assert property (@(posedge CLK) disable iff (RESET) cap_valid |->
        cap_byte == {4'b1010, exp_page, n_start == 2})
    else
    begin
        errors++;
        $display("[ERROR] %0t control byte expected %h got %h", $time,
                 {4'b1010, exp_page, n_start == 2}, cap_byte);
    end

    assert property (@(posedge CLK) disable iff (RESET) idle_chk |-> scl && sda)
    else
    begin
        errors++;
        $display("bus not idle at %0t while no command is in flight", $time);
    end

    assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && sda != $past(sda) |-> i_eeprom_i2c_top.i_cond.cond_busy)
    else
    begin
        errors++;
        $display("SDA changed with SCL high outside a start or stop at %0t", $time);
    end

    assert property (@(posedge CLK) disable iff (RESET) bvalid && !bready |=> bvalid)
    else
    begin
        errors++;
        $display("bvalid dropped before bready at %0t", $time);
    end

    assert property (@(posedge CLK) disable iff (RESET) rvalid && !rready |=> rvalid)
    else
    begin
        errors++;
        $display("rvalid dropped before rready at %0t", $time);
    end

    assert property (@(posedge CLK) disable iff (RESET) wready == awready)
    else
    begin
        errors++;
        $display("[ERROR] %0t wready expected %b got %b", $time, awready, wready);
    end

    assert property (@(posedge CLK) disable iff (RESET) awready |=> bvalid && !$past(bvalid))
    else
    begin
        errors++;
        $display("accepted write without exactly one response at %0t", $time);
    end

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
        int d;
        d = lcg_next() % 4;
        exp_bresp = resp;
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        do
            @(posedge CLK);
        while (!awready);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        repeat (d) @(posedge CLK);
        bready <= 1'b1;
        do
            @(posedge CLK);
        while (!bvalid);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        int d;
        d = lcg_next() % 4;
        araddr <= addr;
        arvalid <= 1'b1;
        do
            @(posedge CLK);
        while (!arready);
        arvalid <= 1'b0;
        repeat (d) @(posedge CLK);
        rready <= 1'b1;
        do
            @(posedge CLK);
        while (!rvalid);
        data = rdata;
        rready <= 1'b0;
    endtask

    task automatic wait_done(input logic [31:0] mask, input logic [31:0] val);
        logic [31:0] st;
        exp_mask = mask;
        exp_val = val;
        chk_poll = 1'b1;
        chk_en = 1'b1;
        do
            axi_read(4'h4, st);
        while (!st[1]);
        chk_en = 1'b0;
        idle_chk = 1'b1;
    endtask

    task automatic post_cmd(input logic op, input logic [10:0] addr, input logic [7:0] data);
        idle_chk = 1'b0;
        exp_page = addr[10:8];
        axi_write(4'h0, {op, 12'h0, addr, data}, 2'b00);
    endtask

    initial
    begin
        logic [31:0] st;
        logic [10:0] addrs [8];
        logic [7:0]  dat;
        CLK = 1'b0;
        RESET = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        model_en = 1'b1;
        seed = 32'hac7b6e06;
        errors = 0;
        cycles = 0;
        cycle_limit = 19 * 5000 + 5000;  // 19 commands plus margin
        chk_en = 1'b0;
        chk_poll = 1'b0;
        idle_chk = 1'b0;
        exp_bresp = 2'b00;
        exp_page = 3'd0;
        n_start = 0;
        cap_cnt = 4'd8;
        cap_valid = 1'b0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        idle_chk = 1'b1;
        repeat (5) @(posedge CLK);

        exp_mask = 32'hffff_ffff;
        exp_val = 32'h0;
        chk_poll = 1'b0;
        chk_en = 1'b1;
        axi_read(4'h4, st);
        chk_en = 1'b0;

        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = lcg_next() >> 5;
            dat = lcg_next() >> 13;
            ref_mem[addrs[i]] = dat;
            post_cmd(1'b0, addrs[i], dat);
            wait_done(32'h0000_0007, 32'h0000_0002);
            post_cmd(1'b1, addrs[i], 8'h00);
            wait_done(32'h0000_ff07, {16'h0, ref_mem[addrs[i]], 8'h02});
        end

        // a second command while busy is refused
        post_cmd(1'b1, addrs[0], 8'h00);
        axi_write(4'h0, {1'b0, 12'h0, addrs[0], ~ref_mem[addrs[0]]}, 2'b10);
        wait_done(32'h0000_ff07, {16'h0, ref_mem[addrs[0]], 8'h02});

        model_en = 1'b0;
        post_cmd(1'b0, addrs[1], 8'h5a);
        wait_done(32'h0000_0007, 32'h0000_0006);
        repeat (20) @(posedge CLK);
        model_en = 1'b1;

        $display("checks done: %0d errors, %0d cycles", errors, cycles);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
